// ==== logic/ldst_pkg.sv ====
package ldst_pkg;

    // Queue sizing, depth must stay a power of two
    localparam int LDST_DEPTH = 4;
    // Index bits, pointers carry one extra wrap bit on top
    localparam int LDST_PTR_W = 2;

    // Data memory of 32-bit words
    localparam int DMEM_WORDS = 64;
    // Word index width
    localparam int DMEM_ADDR_W = 6;

    // Destination register tag
    localparam int TAG_W = 5;

    // Load and store opcodes
    typedef enum logic [2:0] {
        LB  = 3'd0,
        LH  = 3'd1,
        LW  = 3'd2,
        LBU = 3'd3,
        LHU = 3'd4,
        SB  = 3'd5,
        SH  = 3'd6,
        SW  = 3'd7
    } ldst_op_e;

    // Request as issued by the core
    typedef struct packed {
        ldst_op_e         op;
        logic [31:0]      base;
        // Signed immediate, sign-extended in the address stage
        logic [11:0]      offset;
        logic [31:0]      wdata;
        logic [TAG_W-1:0] tag;
    } ldst_req_t;

    // One queue slot, address already formed
    typedef struct packed {
        ldst_op_e         op;
        logic [31:0]      addr;
        logic [31:0]      wdata;
        logic [TAG_W-1:0] tag;
        logic             misaligned;
    } ldst_entry_t;

    // Record handed back to the core
    typedef struct packed {
        logic [TAG_W-1:0] tag;
        logic [31:0]      data;
        // Set on misaligned access
        logic             exc;
    } ldst_result_t;

    // Stores never return a result unless misaligned
    function automatic logic is_store(ldst_op_e op);
        return (op == SB) || (op == SH) || (op == SW);
    endfunction

endpackage

// ==== logic/ldst_agu.sv ====
`timescale 1ns/100ps

module ldst_agu
    import ldst_pkg::*;
(
    // Request from the core
    input  ldst_req_t   req_i,
    input  logic        req_valid_i,

    // Entry towards the request queue
    output ldst_entry_t entry_o,
    output logic        entry_valid_o
);

    // Sign-extended immediate
    logic [31:0] offset_ext;
    // Effective byte address
    logic [31:0] eff_addr;
    // Alignment fault on the effective address
    logic        misaligned;

    // Immediate is 12 bits, replicate its sign bit
    assign offset_ext = {{20{req_i.offset[11]}}, req_i.offset};

    assign eff_addr = req_i.base + offset_ext;

    // Alignment depends on access width only
    always_comb begin
        case (req_i.op)
            // Halfwords need an even address
            LH, LHU, SH: begin
                misaligned = eff_addr[0];
            end
            // Words need both low bits clear
            LW, SW: begin
                misaligned = |eff_addr[1:0];
            end
            // Bytes can sit anywhere
            default: begin
                misaligned = 1'b0;
            end
        endcase
    end

    // Pack the queue entry
    always_comb begin
        entry_o            = '0;
        entry_o.op         = req_i.op;
        entry_o.addr       = eff_addr;
        entry_o.wdata      = req_i.wdata;
        entry_o.tag        = req_i.tag;
        entry_o.misaligned = misaligned;
    end

    // Stage is purely combinational, strobe goes along with the entry
    assign entry_valid_o = req_valid_i;

endmodule

// ==== logic/ldst_buffer.sv ====
`timescale 1ns/100ps

module ldst_buffer
    import ldst_pkg::*;
(
    input  logic        clk_i,
    input  logic        reset_n_i,

    // Enqueue side, valid/ready
    input  ldst_entry_t data_i,
    input  logic        valid_i,
    output logic        ready_o,

    // Dequeue side, valid/yumi
    output logic        valid_o,
    output ldst_entry_t data_o,
    input  logic        yumi_i
);

    // Entry storage
    ldst_entry_t mem_q [LDST_DEPTH];

    // Read and write pointers, top bit marks the wrap
    logic [LDST_PTR_W:0] rd_ptr_q;
    logic [LDST_PTR_W:0] wr_ptr_q;
    logic [LDST_PTR_W:0] rd_ptr_next;
    logic [LDST_PTR_W:0] wr_ptr_next;

    // Status
    logic idx_eq;
    logic wrap_eq;
    logic empty;
    logic full;
    logic enqueue;
    logic dequeue;
    // Exactly one entry held when the next read slot is the write slot
    logic one_left;

    // Next entry to leave, held in a register
    ldst_entry_t head_q;

    assign idx_eq  = rd_ptr_q[LDST_PTR_W-1:0] == wr_ptr_q[LDST_PTR_W-1:0];
    assign wrap_eq = rd_ptr_q[LDST_PTR_W] == wr_ptr_q[LDST_PTR_W];
    assign empty   = idx_eq & wrap_eq;
    assign full    = idx_eq & ~wrap_eq;

    assign ready_o = ~full;
    assign valid_o = ~empty;
    assign data_o  = head_q;

    assign enqueue = valid_i & ready_o;
    assign dequeue = yumi_i & valid_o;

    assign rd_ptr_next = rd_ptr_q + 1'b1;
    assign wr_ptr_next = wr_ptr_q + 1'b1;

    assign one_left = rd_ptr_next[LDST_PTR_W-1:0] == wr_ptr_q[LDST_PTR_W-1:0];

    // Pointer update
    always_ff @(posedge clk_i or negedge reset_n_i) begin
        if (!reset_n_i) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
        end else begin
            if (enqueue) begin
                wr_ptr_q <= wr_ptr_next;
            end
            if (dequeue) begin
                rd_ptr_q <= rd_ptr_next;
            end
        end
    end

    // Storage write
    always_ff @(posedge clk_i) begin
        if (enqueue) begin
            mem_q[wr_ptr_q[LDST_PTR_W-1:0]] <= data_i;
        end
    end

    // Head register
    always_ff @(posedge clk_i) begin
        case ({enqueue, dequeue})
            // First entry goes straight to the head
            2'b10: begin
                if (empty) begin
                    head_q <= data_i;
                end
            end
            // Pull the following entry forward
            2'b01: begin
                head_q <= mem_q[rd_ptr_next[LDST_PTR_W-1:0]];
            end
            // Incoming entry bypasses storage if it is the only one behind the head
            2'b11: begin
                head_q <= one_left ? data_i : mem_q[rd_ptr_next[LDST_PTR_W-1:0]];
            end
            default: begin
            end
        endcase
    end

endmodule

// ==== logic/ldst_mem_ctrl.sv ====
`timescale 1ns/100ps

module ldst_mem_ctrl
    import ldst_pkg::*;
(
    input  logic         clk_i,
    input  logic         reset_n_i,

    // Queue head, valid/yumi
    input  ldst_entry_t  head_i,
    input  logic         head_valid_i,
    output logic         head_yumi_o,

    // Result to the core, valid/yumi
    output ldst_result_t result_o,
    output logic         result_valid_o,
    input  logic         result_yumi_i
);

    // Data memory, contents undefined after reset
    logic [31:0] mem_q [DMEM_WORDS];

    // Word index, wraps modulo memory size
    logic [DMEM_ADDR_W-1:0] word_idx;
    // Byte offset inside the word
    logic [1:0]             byte_off;

    logic        head_store;
    logic        store_ok;
    logic        need_result;
    logic        slot_free;

    // Store lanes
    logic [3:0]  wr_mask;
    logic [31:0] wr_data;

    // Load path
    logic [31:0] rd_word;
    logic [31:0] rd_shift;
    logic [31:0] ld_data;

    // Result register
    ldst_result_t result_q;
    logic         result_valid_q;

    assign word_idx = head_i.addr[DMEM_ADDR_W+1:2];
    assign byte_off = head_i.addr[1:0];

    assign head_store  = is_store(head_i.op);
    assign store_ok    = head_store & ~head_i.misaligned;
    // Loads and every faulting access report back
    assign need_result = ~store_ok;
    // Slot is free when empty or drained this cycle
    assign slot_free   = ~result_valid_q | result_yumi_i;

    assign head_yumi_o = head_valid_i & (store_ok | slot_free);

    // Byte mask and lane-replicated store data
    always_comb begin
        case (head_i.op)
            SB: begin
                wr_mask = 4'b0001 << byte_off;
                wr_data = {4{head_i.wdata[7:0]}};
            end
            SH: begin
                wr_mask = 4'b0011 << {byte_off[1], 1'b0};
                wr_data = {2{head_i.wdata[15:0]}};
            end
            default: begin
                wr_mask = 4'b1111;
                wr_data = head_i.wdata;
            end
        endcase
    end

    // Store write, only the masked bytes
    always_ff @(posedge clk_i) begin
        if (head_yumi_o && store_ok) begin
            for (int b = 0; b < 4; b++) begin
                if (wr_mask[b]) begin
                    mem_q[word_idx][8*b +: 8] <= wr_data[8*b +: 8];
                end
            end
        end
    end

    // Load read, move the addressed lane down to bit 0
    assign rd_word  = mem_q[word_idx];
    assign rd_shift = rd_word >> {byte_off, 3'b000};

    // Width select and extension
    always_comb begin
        case (head_i.op)
            LB:      ld_data = {{24{rd_shift[7]}}, rd_shift[7:0]};
            LBU:     ld_data = {24'h0, rd_shift[7:0]};
            LH:      ld_data = {{16{rd_shift[15]}}, rd_shift[15:0]};
            LHU:     ld_data = {16'h0, rd_shift[15:0]};
            default: ld_data = rd_word;
        endcase
    end

    // Result valid flag
    always_ff @(posedge clk_i or negedge reset_n_i) begin
        if (!reset_n_i) begin
            result_valid_q <= 1'b0;
        end else if (head_yumi_o && need_result) begin
            result_valid_q <= 1'b1;
        end else if (result_yumi_i) begin
            result_valid_q <= 1'b0;
        end
    end

    // Result payload, a fault returns zero data
    always_ff @(posedge clk_i) begin
        if (head_yumi_o && need_result) begin
            result_q.tag  <= head_i.tag;
            result_q.data <= head_i.misaligned ? 32'h0 : ld_data;
            result_q.exc  <= head_i.misaligned;
        end
    end

    assign result_o       = result_q;
    assign result_valid_o = result_valid_q;

endmodule

// ==== logic/ldst_unit.sv ====
`timescale 1ns/100ps

module ldst_unit
    import ldst_pkg::*;
(
    input  logic         clk_i,
    input  logic         reset_n_i,

    // Request from the core
    input  ldst_req_t    req_i,
    input  logic         req_valid_i,
    output logic         req_ready_o,

    // Result to the core
    output ldst_result_t result_o,
    output logic         result_valid_o,
    input  logic         result_yumi_i
);

    // Address stage to queue
    ldst_entry_t agu_entry;
    logic        agu_valid;

    // Queue head to memory stage
    ldst_entry_t head_entry;
    logic        head_valid;
    logic        head_yumi;

    ldst_agu agu_i (
        .req_i         (req_i),
        .req_valid_i   (req_valid_i),
        .entry_o       (agu_entry),
        .entry_valid_o (agu_valid)
    );

    // Queue ready is the unit's ready, address stage adds no delay
    ldst_buffer buffer_i (
        .clk_i     (clk_i),
        .reset_n_i (reset_n_i),
        .data_i    (agu_entry),
        .valid_i   (agu_valid),
        .ready_o   (req_ready_o),
        .valid_o   (head_valid),
        .data_o    (head_entry),
        .yumi_i    (head_yumi)
    );

    ldst_mem_ctrl mem_ctrl_i (
        .clk_i          (clk_i),
        .reset_n_i      (reset_n_i),
        .head_i         (head_entry),
        .head_valid_i   (head_valid),
        .head_yumi_o    (head_yumi),
        .result_o       (result_o),
        .result_valid_o (result_valid_o),
        .result_yumi_i  (result_yumi_i)
    );

endmodule

// ==== verif/ldst_unit_assert.sv ====
`timescale 1ns/100ps

module ldst_unit_assert
    import ldst_pkg::*;
(
    input logic                clk_i,
    input logic                reset_n_i,
    input logic                enq_valid_i,
    input logic                enq_ready_i,
    input logic                deq_valid_i,
    input logic                deq_yumi_i,
    input logic [LDST_PTR_W:0] rd_ptr_i,
    input logic [LDST_PTR_W:0] wr_ptr_i
);

    // Entries held as the pointer distance
    logic [LDST_PTR_W:0] used;
    // Entries held as counted from the two handshakes alone
    logic [LDST_PTR_W:0] count_q;
    // Completed transfers on each side
    logic                enq;
    logic                deq;

    assign used = wr_ptr_i - rd_ptr_i;
    assign enq  = enq_valid_i & enq_ready_i;
    assign deq  = deq_valid_i & deq_yumi_i;

    // Shadow occupancy, kept apart from the queue pointers
    always_ff @(posedge clk_i or negedge reset_n_i) begin
        if (!reset_n_i) begin
            count_q <= '0;
        end else begin
            case ({enq, deq})
                2'b10: begin
                    count_q <= count_q + 1'b1;
                end
                2'b01: begin
                    count_q <= count_q - 1'b1;
                end
                default: begin
                end
            endcase
        end
    end

    // Head offered only while something is stored
    valid_needs_entry: assert property (@(posedge clk_i) disable iff (!reset_n_i)
        deq_valid_i |-> (count_q != '0))
        else $error("Queue offers a head while empty");

    no_enq_when_full: assert property (@(posedge clk_i) disable iff (!reset_n_i)
        !(enq && (int'(count_q) == LDST_DEPTH)))
        else $error("Entry accepted while the queue is full");

    // Consumer may only take what is offered
    yumi_needs_valid: assert property (@(posedge clk_i) disable iff (!reset_n_i)
        deq_yumi_i |-> deq_valid_i)
        else $error("Dequeue strobe without a valid head");

    occupancy_in_range: assert property (@(posedge clk_i) disable iff (!reset_n_i)
        int'(used) <= LDST_DEPTH)
        else $error("Pointer distance exceeds the queue depth");

endmodule

bind ldst_buffer ldst_unit_assert assert_i (
    .clk_i       (clk_i),
    .reset_n_i   (reset_n_i),
    .enq_valid_i (valid_i),
    .enq_ready_i (ready_o),
    .deq_valid_i (valid_o),
    .deq_yumi_i  (yumi_i),
    .rd_ptr_i    (rd_ptr_q),
    .wr_ptr_i    (wr_ptr_q)
);

// ==== verif/ldst_unit_tb.sv ====
`timescale 1ns/100ps

module ldst_unit_tb
    import ldst_pkg::*;
();

    localparam int NUM_ROWS = 26;
    // Allowance per row plus reset and drain
    localparam int MAX_CYCLES = 20 * NUM_ROWS + 200;

    // Request, random data flag, cycles result_yumi_i stays low, expected exc
    typedef struct packed {
        ldst_req_t  req;
        logic       rnd;
        logic [7:0] hold;
        logic       exc;
    } row_t;

    logic         clk_i;
    logic         reset_n_i;
    ldst_req_t    req_i;
    logic         req_valid_i;
    logic         req_ready_o;
    ldst_result_t result_o;
    logic         result_valid_o;
    logic         result_yumi_i;

    row_t         stim_tbl [NUM_ROWS];
    // Pending results in request order, with their hold counts
    ldst_result_t exp_q [$];
    int           hold_q [$];
    // Byte-wide reference memory, addresses wrap at 256
    logic [7:0]   model_mem [256];
    int           errors;
    int           checks;
    int           cycle_cnt;
    int           seed;
    logic         saw_full;

    ldst_unit dut_i (
        .clk_i          (clk_i),
        .reset_n_i      (reset_n_i),
        .req_i          (req_i),
        .req_valid_i    (req_valid_i),
        .req_ready_o    (req_ready_o),
        .result_o       (result_o),
        .result_valid_o (result_valid_o),
        .result_yumi_i  (result_yumi_i)
    );

    always #5 clk_i = ~clk_i;

    task automatic check_result(input ldst_result_t want, input ldst_result_t got);
        checks++;
        if (got.tag !== want.tag) begin
            errors++;
            $display("FAILED t=%0t result_o.tag expected %0d actual %0d", $time, want.tag, got.tag);
        end
        if (got.data !== want.data) begin
            errors++;
            $display("FAILED t=%0t result_o.data expected %h actual %h", $time, want.data, got.data);
        end
        if (got.exc !== want.exc) begin
            errors++;
            $display("FAILED t=%0t result_o.exc expected %b actual %b", $time, want.exc, got.exc);
        end
    endtask

    task automatic check_flag(input string name, input logic want, input logic got);
        checks++;
        if (got !== want) begin
            errors++;
            $display("FAILED t=%0t %s expected %b actual %b", $time, name, want, got);
        end
    endtask

    // Access size in bytes
    function automatic int access_bytes(input ldst_op_e op);
        case (op)
            LB, LBU, SB: return 1;
            LH, LHU, SH: return 2;
            default:     return 4;
        endcase
    endfunction

    // Stores write little-endian bytes, loads gather them and extend
    function automatic logic [31:0] model_access(input ldst_op_e op, input logic [7:0] addr,
                                                 input logic [31:0] wdata);
        logic [31:0] val;
        int          n;
        val = '0;
        n   = access_bytes(op);
        for (int i = 0; i < n; i++) begin
            if (op inside {SB, SH, SW}) begin
                model_mem[addr + 8'(i)] = wdata[8*i +: 8];
            end else begin
                val[8*i +: 8] = model_mem[addr + 8'(i)];
            end
        end
        // Signed loads copy the top loaded bit upward
        if ((op == LB && val[7]) || (op == LH && val[15])) begin
            val = val | (32'hffff_ffff << (8 * n));
        end
        return val;
    endfunction

    initial begin
        ldst_req_t    r;
        ldst_result_t e;
        logic [31:0]  addr;
        logic         mis;
        clk_i         = 1'b0;
        reset_n_i     = 1'b0;
        req_i         = '0;
        req_valid_i   = 1'b0;
        result_yumi_i = 1'b0;
        errors        = 0;
        checks        = 0;
        saw_full      = 1'b0;
        seed          = 32'hef2e5da9;
        // Lane placement and extension of every width
        stim_tbl[0]  = '{'{SW,  32'h00,  12'h000, 32'h8bad_f00d, 5'd1},  1'b0, 8'd0,  1'b0};
        stim_tbl[1]  = '{'{SW,  32'h00,  12'h004, 32'h0,         5'd2},  1'b1, 8'd0,  1'b0};
        stim_tbl[2]  = '{'{SB,  32'h00,  12'h001, 32'h0000_00a5, 5'd3},  1'b0, 8'd0,  1'b0};
        stim_tbl[3]  = '{'{SH,  32'h00,  12'h006, 32'h0000_8001, 5'd4},  1'b0, 8'd0,  1'b0};
        stim_tbl[4]  = '{'{LB,  32'h00,  12'h001, 32'h0,         5'd5},  1'b0, 8'd0,  1'b0};
        stim_tbl[5]  = '{'{LBU, 32'h00,  12'h001, 32'h0,         5'd6},  1'b0, 8'd2,  1'b0};
        stim_tbl[6]  = '{'{LH,  32'h00,  12'h006, 32'h0,         5'd7},  1'b0, 8'd0,  1'b0};
        stim_tbl[7]  = '{'{LHU, 32'h00,  12'h006, 32'h0,         5'd8},  1'b0, 8'd1,  1'b0};
        stim_tbl[8]  = '{'{LW,  32'h00,  12'h004, 32'h0,         5'd9},  1'b0, 8'd0,  1'b0};
        // Misaligned accesses fault and leave memory alone
        stim_tbl[9]  = '{'{SW,  32'h20,  12'h000, 32'h1234_5678, 5'd10}, 1'b0, 8'd0,  1'b0};
        stim_tbl[10] = '{'{SH,  32'h20,  12'h001, 32'h0000_beef, 5'd11}, 1'b0, 8'd0,  1'b1};
        stim_tbl[11] = '{'{SW,  32'h20,  12'h002, 32'hdead_beef, 5'd12}, 1'b0, 8'd0,  1'b1};
        stim_tbl[12] = '{'{LW,  32'h20,  12'h001, 32'h0,         5'd13}, 1'b0, 8'd0,  1'b1};
        stim_tbl[13] = '{'{LW,  32'h20,  12'h000, 32'h0,         5'd14}, 1'b0, 8'd0,  1'b0};
        // Long hold on the first result fills the queue
        stim_tbl[14] = '{'{LW,  32'h00,  12'h000, 32'h0,         5'd15}, 1'b0, 8'd15, 1'b0};
        stim_tbl[15] = '{'{LHU, 32'h00,  12'h002, 32'h0,         5'd16}, 1'b0, 8'd0,  1'b0};
        stim_tbl[16] = '{'{LB,  32'h00,  12'h003, 32'h0,         5'd17}, 1'b0, 8'd0,  1'b0};
        stim_tbl[17] = '{'{LH,  32'h20,  12'h002, 32'h0,         5'd18}, 1'b0, 8'd0,  1'b0};
        stim_tbl[18] = '{'{LBU, 32'h20,  12'h003, 32'h0,         5'd19}, 1'b0, 8'd0,  1'b0};
        stim_tbl[19] = '{'{LW,  32'h00,  12'h004, 32'h0,         5'd20}, 1'b0, 8'd0,  1'b0};
        // Back to back, store then load of the same byte address
        stim_tbl[20] = '{'{SW,  32'h100, 12'h004, 32'h0,         5'd21}, 1'b1, 8'd0,  1'b0};
        stim_tbl[21] = '{'{LW,  32'h40,  12'hfc4, 32'h0,         5'd22}, 1'b0, 8'd0,  1'b0};
        stim_tbl[22] = '{'{SB,  32'h30,  12'h002, 32'h0,         5'd23}, 1'b1, 8'd0,  1'b0};
        stim_tbl[23] = '{'{LBU, 32'h30,  12'h002, 32'h0,         5'd24}, 1'b0, 8'd0,  1'b0};
        stim_tbl[24] = '{'{SH,  32'h30,  12'h000, 32'h0,         5'd25}, 1'b1, 8'd0,  1'b0};
        stim_tbl[25] = '{'{LH,  32'h30,  12'h000, 32'h0,         5'd26}, 1'b0, 8'd0,  1'b0};
        repeat (16) @(posedge clk_i);
        reset_n_i <= 1'b1;
        @(negedge clk_i);
        check_flag("req_ready_o", 1'b1, req_ready_o);
        check_flag("result_valid_o", 1'b0, result_valid_o);
        for (int i = 0; i < NUM_ROWS; i++) begin
            r = stim_tbl[i].req;
            if (stim_tbl[i].rnd) begin
                r.wdata = $random(seed);
            end
            @(posedge clk_i);
            req_i       <= r;
            req_valid_i <= 1'b1;
            // Transfer happens on the first edge that sees ready
            @(negedge clk_i);
            while (!req_ready_o) begin
                saw_full = 1'b1;
                @(negedge clk_i);
            end
            addr = r.base + 32'($signed(r.offset));
            mis  = (int'(addr[1:0]) % access_bytes(r.op)) != 0;
            if (mis !== stim_tbl[i].exc) begin
                errors++;
                $display("Row %0d: table exc %b disagrees with the alignment rule", i, mis);
            end
            e = '{r.tag, (mis ? 32'h0 : model_access(r.op, addr[7:0], r.wdata)), stim_tbl[i].exc};
            // Loads and faulting accesses return a result
            if (mis || !(r.op inside {SB, SH, SW})) begin
                exp_q.push_back(e);
                hold_q.push_back(int'(stim_tbl[i].hold));
            end
        end
        @(posedge clk_i);
        req_valid_i <= 1'b0;
        while (exp_q.size() != 0) begin
            @(negedge clk_i);
        end
        repeat (4) @(negedge clk_i);
        check_flag("result_valid_o", 1'b0, result_valid_o);
        if (!saw_full) begin
            errors++;
            $display("req_ready_o never fell while results were held back");
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // Core result side, checks each result then takes it after its hold
    initial begin
        ldst_result_t want;
        int           hold;
        forever begin
            @(negedge clk_i);
            if (reset_n_i && result_valid_o) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("Result with tag %0d arrived with none pending", result_o.tag);
                end else begin
                    want = exp_q.pop_front();
                    hold = hold_q.pop_front();
                    check_result(want, result_o);
                    repeat (hold) @(negedge clk_i);
                end
                @(posedge clk_i);
                result_yumi_i <= 1'b1;
                @(posedge clk_i);
                result_yumi_i <= 1'b0;
            end
        end
    end

    // Run limit scaled to the table length
    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < MAX_CYCLES) begin
            @(posedge clk_i);
            cycle_cnt++;
        end
        $display("Timeout after %0d cycles with %0d results pending", cycle_cnt, exp_q.size());
        $display("Checks: %0d, errors: %0d", checks, errors);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

// ==== ldst_unit.f ====
logic/ldst_pkg.sv
logic/ldst_agu.sv
logic/ldst_buffer.sv
logic/ldst_mem_ctrl.sv
logic/ldst_unit.sv
verif/ldst_unit_assert.sv
verif/ldst_unit_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the ldst_unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

top=ldst_unit_tb
log=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module "$top" -f ldst_unit.f -o "$top"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/"$top" | tee "$log"
if [ "${PIPESTATUS[0]}" -ne 0 ]; then
    echo "Simulation exited with an error status"
    exit 1
fi

if grep -q "STATUS: FAIL" "$log"; then
    exit 1
fi
exit 0
